// File: logic/tpu_pkg.sv
// shared sizes, element types and command codes for the 4x4 accelerator
// all sizes are fixed by the array edge and are not meant to be changed alone
`default_nettype none

package tpu_pkg;

  // array geometry and buffer sizes
  localparam int ARRAY_DIM    = 4;
  localparam int K_MAX        = 256;
  localparam int AB_ADDR_W    = 8;
  localparam int C_ADDR_W     = 2;
  // last operand word needs this many extra hops to reach cell (3,3)
  localparam int DRAIN_CYCLES = 2 * (ARRAY_DIM - 1);

  typedef logic signed [7:0]  operand_t;
  // accumulator wraps modulo 2^32
  typedef logic signed [31:0] acc_t;

  // element 0 is the most significant lane
  typedef operand_t [0:ARRAY_DIM-1] ab_word_t;
  typedef acc_t     [0:ARRAY_DIM-1] c_row_t;

  // codes outside this set are answered with a zero response
  typedef enum logic [6:0] {
    OP_WRITE_A = 7'd0,
    OP_WRITE_B = 7'd1,
    OP_COMPUTE = 7'd2,
    OP_READ_C  = 7'd3
  } funct_e;

  typedef struct packed {
    funct_e      funct;
    // A/B index, depth K or C row
    logic [31:0] arg0;
    // operand word, or column select in bits 1:0
    logic [31:0] arg1;
  } cmd_t;

  typedef struct packed {
    logic                en;
    logic [C_ADDR_W-1:0] row;
    c_row_t              data;
  } c_wr_t;

endpackage

`default_nettype wire

// File: logic/gbuff.sv
// single-port buffer of K_MAX words, read data appears one cycle after the index
// a write cycle does not update rdata
`timescale 1ns/1ps
`default_nettype none

module gbuff
  import tpu_pkg::*;
#(
  parameter type word_t = ab_word_t
) (
  input  logic                 clk,
  input  logic                 we,
  input  logic [AB_ADDR_W-1:0] index,
  input  word_t                wdata,
  output word_t                rdata
);

  word_t mem [K_MAX];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[index] <= wdata;
    end else begin
      rdata <= mem[index];
    end
  end

  // an unknown enable would corrupt the word silently
  a_we_known: assert property (@(posedge clk) !$isunknown(we))
    else $error("gbuff write enable is unknown");

endmodule

`default_nettype wire

// File: logic/pe.sv
// output-stationary MAC cell, operands move one hop per cycle
// clear has priority over the product of the same cycle
`timescale 1ns/1ps
`default_nettype none

module pe
  import tpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     clear,
  input  operand_t west,
  input  operand_t north,
  output operand_t east,
  output operand_t south,
  output acc_t     acc
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      east  <= '0;
      south <= '0;
      acc   <= '0;
    end else begin
      east  <= west;
      south <= north;
      if (clear) begin
        acc <= '0;
      end else begin
        // signed product, sum wraps at 32 bits
        acc <= acc + acc_t'(west) * acc_t'(north);
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/systolic_array.sv
// 4x4 grid of pe with triangular input skew on the west and north edges
// inputs must be held at zero whenever no operand word is being fed
`timescale 1ns/1ps
`default_nettype none

module systolic_array
  import tpu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     clear,
  input  ab_word_t west_word,
  input  ab_word_t north_word,
  output c_row_t   rows [ARRAY_DIM]
);

  // links between cells, index ARRAY_DIM is the far edge
  operand_t h_link [ARRAY_DIM][ARRAY_DIM+1];
  operand_t v_link [ARRAY_DIM+1][ARRAY_DIM];
  acc_t     acc    [ARRAY_DIM][ARRAY_DIM];

  for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_skew
    if (i == 0) begin : g_direct
      assign h_link[i][0] = west_word[i];
      assign v_link[0][i] = north_word[i];
    end else begin : g_delay
      // lane i is delayed by i cycles
      operand_t west_sr  [i];
      operand_t north_sr [i];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          for (int s = 0; s < i; s++) begin
            west_sr[s]  <= '0;
            north_sr[s] <= '0;
          end
        end else begin
          west_sr[0]  <= west_word[i];
          north_sr[0] <= north_word[i];
          for (int s = 1; s < i; s++) begin
            west_sr[s]  <= west_sr[s-1];
            north_sr[s] <= north_sr[s-1];
          end
        end
      end

      assign h_link[i][0] = west_sr[i-1];
      assign v_link[0][i] = north_sr[i-1];
    end
  end

  for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
    for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
      pe i_pe (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (clear),
        .west  (h_link[r][c]),
        .north (v_link[r][c]),
        .east  (h_link[r][c+1]),
        .south (v_link[r+1][c]),
        .acc   (acc[r][c])
      );

      assign rows[r][c] = acc[r][c];
    end
  end

endmodule

`default_nettype wire

// File: logic/tpu_engine.sv
// runs one 4x4 tile: clear, K operand reads, drain, then four row writes to C
// never stalls, so the buffers must be free for the whole run
`timescale 1ns/1ps
`default_nettype none

module tpu_engine
  import tpu_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic [AB_ADDR_W:0]   k_len,
  output logic [AB_ADDR_W-1:0] a_index,
  output logic [AB_ADDR_W-1:0] b_index,
  input  ab_word_t             a_word,
  input  ab_word_t             b_word,
  output c_wr_t                c_wr,
  output logic                 done
);

  typedef logic [AB_ADDR_W:0] cnt_t;

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_FEED,
    PH_DRAIN,
    PH_WRITE,
    PH_DONE
  } phase_e;

  phase_e phase;
  cnt_t   cnt;
  cnt_t   k_q;
  logic   clear_q;
  // high while a_word and b_word carry requested data
  logic   rd_valid;
  logic   done_q;

  logic                wr_en_q;
  logic [C_ADDR_W-1:0] wr_row_q;
  c_row_t              wr_data_q;

  ab_word_t west_word;
  ab_word_t north_word;
  c_row_t   rows [ARRAY_DIM];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase    <= PH_IDLE;
      cnt      <= '0;
      k_q      <= '0;
      clear_q  <= 1'b0;
      rd_valid <= 1'b0;
      done_q   <= 1'b0;
      wr_en_q  <= 1'b0;
    end else begin
      clear_q  <= start;
      rd_valid <= (phase == PH_FEED);
      wr_en_q  <= (phase == PH_WRITE);
      done_q   <= (phase == PH_DONE);
      case (phase)
        PH_IDLE: begin
          if (start) begin
            phase <= PH_FEED;
            cnt   <= '0;
            k_q   <= k_len;
          end
        end
        PH_FEED: begin
          // one read per cycle, word cnt of both buffers
          if (cnt == k_q - 1'b1) begin
            phase <= PH_DRAIN;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        PH_DRAIN: begin
          if (cnt == cnt_t'(DRAIN_CYCLES - 1)) begin
            phase <= PH_WRITE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        PH_WRITE: begin
          if (cnt == cnt_t'(ARRAY_DIM - 1)) begin
            phase <= PH_DONE;
            cnt   <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        PH_DONE: phase <= PH_IDLE;
        default: phase <= PH_IDLE;
      endcase
    end
  end

  // row cnt is already final when it is captured here
  always_ff @(posedge clk) begin
    if (phase == PH_WRITE) begin
      wr_row_q  <= cnt[C_ADDR_W-1:0];
      wr_data_q <= rows[cnt[C_ADDR_W-1:0]];
    end
  end

  assign a_index = cnt[AB_ADDR_W-1:0];
  assign b_index = cnt[AB_ADDR_W-1:0];

  // stale buffer data must not reach the array
  assign west_word  = rd_valid ? a_word : '0;
  assign north_word = rd_valid ? b_word : '0;

  systolic_array i_array (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear      (clear_q),
    .west_word  (west_word),
    .north_word (north_word),
    .rows       (rows)
  );

  assign c_wr = '{en: wr_en_q, row: wr_row_q, data: wr_data_q};
  assign done = done_q;

  a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> phase == PH_IDLE)
    else $error("compute started while the engine is busy");

  a_k_range: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> (k_len >= 1 && k_len <= K_MAX))
    else $error("compute depth out of range");

endmodule

`default_nettype wire

// File: logic/cfu_top.sv
// command/response front end, one command in flight at a time
// K must lie in 1..K_MAX; C holds garbage until the first compute
`timescale 1ns/1ps
`default_nettype none

module cfu_top
  import tpu_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        cmd_valid,
  output logic        cmd_ready,
  input  cmd_t        cmd_payload,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output logic [31:0] rsp_payload
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_EXEC,
    S_COMPUTE,
    S_RESPOND
  } state_e;

  state_e state;
  cmd_t   cmd_q;

  logic                 a_we;
  logic                 b_we;
  logic [AB_ADDR_W-1:0] a_index;
  logic [AB_ADDR_W-1:0] b_index;
  logic [AB_ADDR_W-1:0] c_index;
  logic [C_ADDR_W-1:0]  c_row_sel;
  ab_word_t             a_rdata;
  ab_word_t             b_rdata;
  c_row_t               c_rdata;
  acc_t                 rd_elem;

  logic                 start;
  logic                 done;
  logic [AB_ADDR_W-1:0] eng_a_index;
  logic [AB_ADDR_W-1:0] eng_b_index;
  c_wr_t                eng_c_wr;

  assign cmd_ready = (state == S_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      rsp_valid <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd_valid) begin
            state <= S_EXEC;
          end
        end
        S_EXEC: begin
          if (cmd_q.funct == OP_COMPUTE) begin
            state <= S_COMPUTE;
          end else begin
            state <= S_RESPOND;
          end
        end
        S_COMPUTE: begin
          if (done) begin
            state <= S_RESPOND;
          end
        end
        S_RESPOND: begin
          // first cycle loads the payload, then wait for the host
          if (!rsp_valid) begin
            rsp_valid <= 1'b1;
          end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
            state     <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      cmd_q <= cmd_payload;
    end
  end

  // only a read returns data
  always_ff @(posedge clk) begin
    if (state == S_RESPOND && !rsp_valid) begin
      rsp_payload <= (cmd_q.funct == OP_READ_C) ? rd_elem : '0;
    end
  end

  assign rd_elem = c_rdata[cmd_q.arg1[1:0]];

  // engine owns the read side of A/B and the C write while computing
  assign a_we      = (state == S_EXEC) && (cmd_q.funct == OP_WRITE_A);
  assign b_we      = (state == S_EXEC) && (cmd_q.funct == OP_WRITE_B);
  assign a_index   = (state == S_COMPUTE) ? eng_a_index : cmd_q.arg0[AB_ADDR_W-1:0];
  assign b_index   = (state == S_COMPUTE) ? eng_b_index : cmd_q.arg0[AB_ADDR_W-1:0];
  assign c_row_sel = (state == S_COMPUTE) ? eng_c_wr.row : cmd_q.arg0[C_ADDR_W-1:0];
  assign c_index   = {{(AB_ADDR_W - C_ADDR_W){1'b0}}, c_row_sel};
  assign start     = (state == S_EXEC) && (cmd_q.funct == OP_COMPUTE);

  gbuff #(.word_t(ab_word_t)) i_gbuff_a (
    .clk   (clk),
    .we    (a_we),
    .index (a_index),
    .wdata (ab_word_t'(cmd_q.arg1)),
    .rdata (a_rdata)
  );

  gbuff #(.word_t(ab_word_t)) i_gbuff_b (
    .clk   (clk),
    .we    (b_we),
    .index (b_index),
    .wdata (ab_word_t'(cmd_q.arg1)),
    .rdata (b_rdata)
  );

  gbuff #(.word_t(c_row_t)) i_gbuff_c (
    .clk   (clk),
    .we    (eng_c_wr.en),
    .index (c_index),
    .wdata (eng_c_wr.data),
    .rdata (c_rdata)
  );

  tpu_engine i_engine (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .k_len   (cmd_q.arg0[AB_ADDR_W:0]),
    .a_index (eng_a_index),
    .b_index (eng_b_index),
    .a_word  (a_rdata),
    .b_word  (b_rdata),
    .c_wr    (eng_c_wr),
    .done    (done)
  );

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_payload))
    else $error("response dropped or changed under back-pressure");

  // a C write outside a compute would race a host read
  a_c_wr_owner: assert property (@(posedge clk) disable iff (!rst_n)
    eng_c_wr.en |-> state == S_COMPUTE)
    else $error("engine wrote C outside a compute");

endmodule

`default_nettype wire

// File: bench/tb_cfu.sv
// random operand tiles checked against a C = A*B model in the testbench
// one command in flight; every response and C element is compared in hex
`timescale 1ns/1ps
`default_nettype none

module tb_cfu
  import tpu_pkg::*;
;

  localparam int CLK_PERIOD = 20;
  // worst case per tile: K writes to A and B, one compute, 16 reads
  localparam int NUM_CMDS = 4 * (2 * K_MAX + 17) + 64;
  localparam longint WATCHDOG_NS = longint'(NUM_CMDS) * (K_MAX + 32) * CLK_PERIOD;

  localparam int FILL_RANDOM = 0;
  localparam int FILL_MIN    = 1;
  localparam int FILL_MIXED  = 2;

  logic        clk;
  logic        rst_n;
  logic        cmd_valid;
  logic        cmd_ready;
  cmd_t        cmd_payload;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [31:0] rsp_payload;

  logic [31:0] rng_state;
  ab_word_t    a_mem [K_MAX];
  ab_word_t    b_mem [K_MAX];
  acc_t        c_model [ARRAY_DIM][ARRAY_DIM];

  cfu_top i_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .cmd_payload (cmd_payload),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_payload (rsp_payload)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_elem(input acc_t got, input acc_t exp, input string name);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // entered and left on a falling edge
  task automatic issue(input funct_e f, input logic [31:0] a0, input logic [31:0] a1,
                       input int hold, output logic [31:0] rsp);
    int waited;
    check_flag(cmd_ready, 1'b1, "cmd_ready");
    cmd_valid   = 1'b1;
    cmd_payload = '{funct: f, arg0: a0, arg1: a1};
    @(negedge clk);
    cmd_valid = 1'b0;
    waited    = 0;
    while (!rsp_valid) begin
      check_flag(cmd_ready, 1'b0, "cmd_ready");
      if (waited > K_MAX + 32) begin
        $display("no response after %0d cycles", waited);
        abort_run();
      end
      @(negedge clk);
      waited++;
    end
    // everything but a compute answers 2 cycles after the accepting edge
    if (f != OP_COMPUTE && waited != 2) begin
      $display("response came %0d cycles after the command, expected 2", waited);
      abort_run();
    end
    rsp = rsp_payload;
    for (int h = 0; h < hold; h++) begin
      @(negedge clk);
      check_flag(rsp_valid, 1'b1, "rsp_valid");
      check_elem(rsp_payload, rsp, "rsp_payload");
      check_flag(cmd_ready, 1'b0, "cmd_ready");
    end
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
    check_flag(rsp_valid, 1'b0, "rsp_valid");
  endtask

  task automatic fill_operands(input int mode);
    logic [31:0] r;
    logic        sgn;
    for (int k = 0; k < K_MAX; k++) begin
      r = rand32();
      a_mem[k] = r;
      b_mem[k] = rand32();
      for (int e = 0; e < ARRAY_DIM; e++) begin
        sgn = (((k + e) % 2) == 1);
        if (mode == FILL_MIN) begin
          a_mem[k][e] = 8'h80;
          b_mem[k][e] = 8'h80;
        end else if (mode == FILL_MIXED) begin
          // opposite signs in A and B, swapped on alternate lanes
          a_mem[k][e] = {sgn, r[6:0]};
          b_mem[k][e] = {~sgn, r[14:8]};
        end
      end
    end
  endtask

  task automatic load_operands(input int k);
    logic [31:0] rsp;
    for (int i = 0; i < k; i++) begin
      issue(OP_WRITE_A, i, a_mem[i], 0, rsp);
      check_elem(rsp, '0, "write A response");
      issue(OP_WRITE_B, i, b_mem[i], 0, rsp);
      check_elem(rsp, '0, "write B response");
    end
  endtask

  function automatic void compute_model(input int k);
    operand_t ea;
    operand_t eb;
    acc_t     sum;
    for (int r = 0; r < ARRAY_DIM; r++) begin
      for (int c = 0; c < ARRAY_DIM; c++) begin
        sum = '0;
        for (int kk = 0; kk < k; kk++) begin
          ea  = a_mem[kk][r];
          eb  = b_mem[kk][c];
          sum = sum + acc_t'(ea) * acc_t'(eb);
        end
        c_model[r][c] = sum;
      end
    end
  endfunction

  task automatic run_compute(input int k);
    logic [31:0] rsp;
    issue(OP_COMPUTE, k, '0, 0, rsp);
    check_elem(rsp, '0, "compute response");
    compute_model(k);
  endtask

  // hold_max of 1 means no back-pressure
  task automatic read_all_c(input int hold_max);
    logic [31:0] rsp;
    int          hold;
    for (int r = 0; r < ARRAY_DIM; r++) begin
      for (int c = 0; c < ARRAY_DIM; c++) begin
        hold = int'(rand32() % 32'(hold_max));
        issue(OP_READ_C, r, c, hold, rsp);
        check_elem(rsp, c_model[r][c], $sformatf("C[%0d][%0d]", r, c));
      end
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    abort_run();
  end

  initial begin
    logic [31:0] rsp;
    int          k;
    rng_state   = 32'hdae1;
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd_payload = '0;
    rsp_ready   = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag(cmd_ready, 1'b1, "cmd_ready");
    check_flag(rsp_valid, 1'b0, "rsp_valid");

    // random tile with random depth, light back-pressure on reads
    fill_operands(FILL_RANDOM);
    k = int'(rand32() % 32'(K_MAX)) + 1;
    load_operands(k);
    run_compute(k);
    read_all_c(4);

    // shortest depth
    fill_operands(FILL_RANDOM);
    load_operands(1);
    run_compute(1);
    read_all_c(1);

    // largest magnitudes, every sum is 128 * 128 * K
    fill_operands(FILL_MIN);
    load_operands(K_MAX);
    run_compute(K_MAX);
    for (int r = 0; r < ARRAY_DIM; r++) begin
      for (int c = 0; c < ARRAY_DIM; c++) begin
        issue(OP_READ_C, r, c, 0, rsp);
        check_elem(rsp, acc_t'(128 * 128 * K_MAX), $sformatf("C[%0d][%0d]", r, c));
      end
    end

    fill_operands(FILL_MIXED);
    load_operands(K_MAX);
    run_compute(K_MAX);
    read_all_c(2);

    // shorter depths on the same buffers give prefix sums
    k = int'(rand32() % 32'(K_MAX - 1)) + 1;
    run_compute(k);
    read_all_c(1);
    k = int'(rand32() % 32'(k)) + 1;
    run_compute(k);
    read_all_c(1);

    // long stalls on the response channel
    for (int n = 0; n < 4; n++) begin
      issue(OP_READ_C, n, 3 - n, 4 + int'(rand32() % 32'd12), rsp);
      check_elem(rsp, c_model[n][3-n], $sformatf("C[%0d][%0d]", n, 3 - n));
    end

    issue(funct_e'(7'h5a), 32'h1, 32'h2, 2, rsp);
    check_elem(rsp, '0, "unknown command response");
    read_all_c(1);

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
logic/tpu_pkg.sv
logic/gbuff.sv
logic/pe.sv
logic/systolic_array.sv
logic/tpu_engine.sv
logic/cfu_top.sv
bench/tb_cfu.sv

// File: Makefile
# Verilator build and run for the accelerator testbench

VERILATOR ?= verilator
TOP       ?= tb_cfu
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass message appears in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
